/* intr_test.f */
intr_test_pkg.sv
csr_mgr.sv
intr_engine.sv
intr_rsp_tracker.sv
intr_test_afu.sv
tb_intr_host.sv
tb_intr_test_afu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the interrupt test simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_intr_test_afu \
    -f intr_test.f \
    -o sim_intr_test

output=$(./obj_dir/sim_intr_test 2>&1) || true
echo "$output"

if grep -q "^Result: PASSED$" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* tb_intr_test_afu.sv */
// Interrupt test AFU testbench

`timescale 1ns/1ps

module tb_intr_test_afu;

    import intr_test_pkg::*;

    logic         clk;
    logic         reset_n;
    mmio_req_t    mmio;
    logic         mmio_readdatavalid;
    csr_data_t    mmio_readdata;
    host_wr_req_t host_wr;
    logic         host_waitrequest;
    host_wr_rsp_t host_rsp;
    logic [1:0]   fault_kind;

    // Scoreboard state of the current run
    int   run_max;
    int   exp_id;
    int   acc_count;
    int   rsp_count;
    logic fall_due;

    intr_test_afu i_intr_test_afu (
        .clk                (clk),
        .reset_n            (reset_n),
        .mmio               (mmio),
        .mmio_readdatavalid (mmio_readdatavalid),
        .mmio_readdata      (mmio_readdata),
        .host_wr            (host_wr),
        .host_waitrequest   (host_waitrequest),
        .host_rsp           (host_rsp)
    );

    tb_intr_host i_tb_intr_host (
        .clk              (clk),
        .reset_n          (reset_n),
        .host_wr          (host_wr),
        .host_waitrequest (host_waitrequest),
        .fault_kind       (fault_kind),
        .host_rsp         (host_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================================
    // Reporting
    // ==================================================================

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
            fail_run($sformatf("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                               $time, name, got, exp));
    endtask

    // Read data valid is the read strobe one cycle late
    assert property (@(posedge clk) disable iff (!reset_n)
                     mmio_readdatavalid == $past(mmio.read))
    else
        fail_run($sformatf("CHECK FAILED at %0t: mmio_readdatavalid got %0b expected %0b",
                           $time, mmio_readdatavalid, !mmio_readdatavalid));

    // First request goes out two cycles after the MMIO write to register 0
    assert property (@(posedge clk) disable iff (!reset_n)
                     $rose(host_wr.write) |-> $past(mmio.write && (mmio.address == '0), 2))
    else
        fail_run($sformatf("CHECK FAILED at %0t: host_wr.write got %0b expected %0b",
                           $time, 1'b1, 1'b0));

    // A stalled request holds every field
    assert property (@(posedge clk) disable iff (!reset_n)
                     (host_wr.write && host_waitrequest) |=> $stable(host_wr))
    else
        fail_run($sformatf("CHECK FAILED at %0t: host_wr got 0x%0h expected held value",
                           $time, host_wr));

    // ==================================================================
    // Request monitor, sampled mid-cycle
    // ==================================================================

    always @(negedge clk)
    begin
        logic [USER_W-1:0] exp_user;

        if (reset_n)
        begin
            // Write drops right after the last ID is taken
            if (fall_due)
            begin
                check_value("host_wr.write", 64'(host_wr.write), 64'd0);
            end
            fall_due = 1'b0;

            if (host_wr.write && !host_waitrequest)
            begin
                assert (exp_id <= run_max)
                else
                    fail_run("Request issued beyond the maximum interrupt ID");
                exp_user = USER_W'(1 << UFLAG_INTERRUPT) | USER_W'(exp_id << UFLAG_ID_LSB);
                check_value("host_wr.address", 64'(host_wr.address), 64'(exp_id));
                check_value("host_wr.user", 64'(host_wr.user), 64'(exp_user));
                if (exp_id == run_max)
                begin
                    fall_due = 1'b1;
                end
                exp_id++;
                acc_count++;
            end

            if (host_rsp.valid)
            begin
                rsp_count++;
            end
        end
    end

    // ==================================================================
    // MMIO tasks
    // ==================================================================

    task automatic mmio_write(input int idx, input csr_data_t data);
        @(posedge clk);
        mmio <= '{write: 1'b1, read: 1'b0, address: CSR_IDX_W'(idx), writedata: data};
        @(posedge clk);
        mmio <= '0;
    endtask

    // Fixed one cycle read latency
    task automatic mmio_read(input int idx, output csr_data_t data);
        @(posedge clk);
        mmio <= '{write: 1'b0, read: 1'b1, address: CSR_IDX_W'(idx), writedata: '0};
        @(posedge clk);
        mmio <= '0;
        @(negedge clk);
        check_value("mmio_readdatavalid", 64'(mmio_readdatavalid), 64'd1);
        data = mmio_readdata;
    endtask

    function automatic csr_data_t expected_csr(input int idx);
        case (idx)
            0: return TEST_ID[63:0];
            1: return TEST_ID[127:64];
            2: return {48'd0, 8'(NUM_INTR_IDS), 8'd1};
            default: return '0;
        endcase
    endfunction

    // One run from ID 0 to max_id, optionally with a faulted response
    task automatic run_ids(input int max_id, input logic [1:0] fault);
        int          cnt;
        int          wait_cycles;
        csr_data_t   rd;
        logic [15:0] exp_mask;

        @(posedge clk);
        fault_kind <= fault;
        run_max   = max_id;
        exp_id    = 0;
        acc_count = 0;
        rsp_count = 0;
        mmio_write(0, 64'(max_id));

        // Status clears before any response lands
        mmio_read(3, rd);
        check_value("status after start", rd, 64'd0);

        // Run is over once write has dropped and every accepted request is answered
        wait_cycles = 0;
        while (acc_count == 0 || host_wr.write || rsp_count < acc_count)
        begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 300)
            begin
                fail_run($sformatf("Timeout waiting for the end of run with max ID %0d",
                                   max_id));
            end
        end
        check_value("accepted requests", 64'(acc_count), 64'(max_id + 1));

        // First response carries ID 0, so a dropped flag loses bit 0
        exp_mask = 16'((1 << (max_id + 1)) - 1);
        cnt      = max_id + 1;
        if (fault == 2'd1)
        begin
            exp_mask[0] = 1'b0;
            cnt         = max_id;
        end
        mmio_read(3, rd);
        check_value("status register", rd, {39'd0, fault != 2'd0, exp_mask, 8'(cnt)});
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial
    begin
        csr_data_t rd;

        reset_n    = 1'b0;
        mmio       = '0;
        fault_kind = 2'd0;
        run_max    = 0;
        exp_id     = 0;
        acc_count  = 0;
        rsp_count  = 0;
        fall_due   = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        // Identity, configuration and unused registers
        for (int i = 0; i < NUM_CSRS; i++)
        begin
            mmio_read(i, rd);
            check_value($sformatf("register %0d", i), rd, expected_csr(i));
        end

        // Clean runs over every maximum ID
        for (int n = 0; n < NUM_INTR_IDS; n++)
        begin
            run_ids(n, 2'd0);
        end

        // Dropped interrupt flag, then recovery
        run_ids(3, 2'd1);
        run_ids(2, 2'd0);
        // Fence flag still counts but flags an error
        run_ids(1, 2'd2);
        run_ids(3, 2'd0);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* tb_intr_host.sv */
// Host write channel model

`timescale 1ns/1ps

module tb_intr_host
(
    input  logic                        clk,
    input  logic                        reset_n,

    // Request from the DUT and back-pressure to it
    input  intr_test_pkg::host_wr_req_t host_wr,
    output logic                        host_waitrequest,

    // Fault select: 1 clears the interrupt flag, 2 sets the fence flag
    input  logic [1:0]                  fault_kind,

    // Write responses back to the DUT
    output intr_test_pkg::host_wr_rsp_t host_rsp
);

    import intr_test_pkg::*;

    integer seed;
    int     cycle;
    int     last_due;
    logic   fault_done;

    // Accepted requests waiting for their response
    logic [USER_W-1:0] pend_user [$];
    int                pend_due [$];

    initial
    begin
        seed             = 19323;
        cycle            = 0;
        last_due         = 0;
        fault_done       = 1'b0;
        host_waitrequest = 1'b1;
        host_rsp         = '0;
    end

    always @(posedge clk)
    begin
        int                due;
        logic [USER_W-1:0] rsp_user;

        cycle = cycle + 1;
        if (!reset_n)
        begin
            pend_user.delete();
            pend_due.delete();
            fault_done = 1'b0;
            host_waitrequest <= 1'b1;
            host_rsp         <= '0;
        end
        else
        begin
            // Queue the request on acceptance, reply 1 to 6 cycles later
            if (host_wr.write && !host_waitrequest)
            begin
                due = cycle + 1 + int'($unsigned($random(seed)) % 6);
                // Keep responses in request order
                if (due <= last_due)
                begin
                    due = last_due + 1;
                end
                last_due = due;
                pend_user.push_back(host_wr.user);
                pend_due.push_back(due);
            end

            // At most one response per cycle
            if (pend_due.size() > 0 && pend_due[0] <= cycle)
            begin
                rsp_user = pend_user.pop_front();
                pend_due.delete(0);
                // One faulted response per armed fault
                if (fault_kind != 2'd0 && !fault_done)
                begin
                    if (fault_kind == 2'd1)
                    begin
                        rsp_user[UFLAG_INTERRUPT] = 1'b0;
                    end
                    else
                    begin
                        rsp_user[UFLAG_FENCE] = 1'b1;
                    end
                    fault_done = 1'b1;
                end
                host_rsp <= '{valid: 1'b1, user: rsp_user};
            end
            else
            begin
                host_rsp <= '0;
            end

            // Disarm clears the one-shot
            if (fault_kind == 2'd0)
            begin
                fault_done = 1'b0;
            end

            // Roughly 40 percent stall
            host_waitrequest <= (($unsigned($random(seed)) % 5) < 2);
        end
    end

endmodule

/* intr_test_afu.sv */
// Interrupt test AFU top level

`timescale 1ns/1ps

module intr_test_afu
(
    input  logic                        clk,
    input  logic                        reset_n,

    // MMIO port
    input  intr_test_pkg::mmio_req_t    mmio,
    output logic                        mmio_readdatavalid,
    output intr_test_pkg::csr_data_t    mmio_readdata,

    // Host write channel
    output intr_test_pkg::host_wr_req_t host_wr,
    input  logic                        host_waitrequest,
    input  intr_test_pkg::host_wr_rsp_t host_rsp
);

    import intr_test_pkg::*;

    csr_wr_t   glob_wr;
    csr_data_t glob_rd_data [NUM_CSRS];

    // Status from the tracker
    logic [7:0]              num_rsp;
    logic [NUM_INTR_IDS-1:0] rsp_mask;
    logic                    rsp_error;

    // ==================================================================
    // Global register file
    // ==================================================================

    always_comb
    begin
        glob_rd_data[0] = TEST_ID[63:0];
        glob_rd_data[1] = TEST_ID[127:64];
        // Configuration: ID count and engine count
        glob_rd_data[2] = {48'd0, 8'(NUM_INTR_IDS), 8'(NUM_ENGINES)};
        // Status: error, answered mask, response count
        glob_rd_data[3] = {39'd0, rsp_error, 16'(rsp_mask), num_rsp};

        for (int i = 4; i < NUM_CSRS; i++)
        begin
            glob_rd_data[i] = '0;
        end
    end

    // ==================================================================
    // Blocks
    // ==================================================================

    csr_mgr i_csr_mgr (
        .clk                (clk),
        .reset_n            (reset_n),
        .mmio               (mmio),
        .glob_rd_data       (glob_rd_data),
        .mmio_readdatavalid (mmio_readdatavalid),
        .mmio_readdata      (mmio_readdata),
        .glob_wr            (glob_wr)
    );

    intr_engine i_intr_engine (
        .clk              (clk),
        .reset_n          (reset_n),
        .glob_wr          (glob_wr),
        .host_waitrequest (host_waitrequest),
        .host_wr          (host_wr)
    );

    intr_rsp_tracker i_intr_rsp_tracker (
        .clk       (clk),
        .reset_n   (reset_n),
        .glob_wr   (glob_wr),
        .host_rsp  (host_rsp),
        .num_rsp   (num_rsp),
        .rsp_mask  (rsp_mask),
        .rsp_error (rsp_error)
    );

endmodule

/* intr_rsp_tracker.sv */
// Interrupt response tracker

`timescale 1ns/1ps

module intr_rsp_tracker
(
    input  logic                                  clk,
    input  logic                                  reset_n,

    // Start command comes from a write to register 0
    input  intr_test_pkg::csr_wr_t                glob_wr,

    // Host write responses
    input  intr_test_pkg::host_wr_rsp_t           host_rsp,

    // Status for register 3
    output logic [7:0]                            num_rsp,
    output logic [intr_test_pkg::NUM_INTR_IDS-1:0] rsp_mask,
    output logic                                  rsp_error
);

    import intr_test_pkg::*;

    logic start_cmd;
    assign start_cmd = glob_wr.req && (glob_wr.idx == '0);

    // ID echoed in the response user field
    intr_id_t rsp_id;
    assign rsp_id = host_rsp.user[UFLAG_ID_LSB +: INTR_ID_W];

    // Good interrupt response
    logic rsp_intr;
    assign rsp_intr = host_rsp.valid && host_rsp.user[UFLAG_INTERRUPT];

    // Missing interrupt flag or unexpected fence
    logic rsp_bad;
    assign rsp_bad = host_rsp.valid &&
                     (!host_rsp.user[UFLAG_INTERRUPT] || host_rsp.user[UFLAG_FENCE]);

    // Start wins over a response in the same cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n || start_cmd)
        begin
            num_rsp   <= '0;
            rsp_mask  <= '0;
            rsp_error <= 1'b0;
        end
        else
        begin
            if (rsp_intr)
            begin
                num_rsp          <= num_rsp + 1'b1;
                rsp_mask[rsp_id] <= 1'b1;
            end

            // Sticky until the next start
            if (rsp_bad)
            begin
                rsp_error <= 1'b1;
            end
        end
    end

endmodule

/* intr_engine.sv */
// Interrupt request issue loop

`timescale 1ns/1ps

module intr_engine
(
    input  logic                       clk,
    input  logic                       reset_n,

    // Global register writes, index 0 starts a run
    input  intr_test_pkg::csr_wr_t     glob_wr,

    // Host write channel
    input  logic                       host_waitrequest,
    output intr_test_pkg::host_wr_req_t host_wr
);

    import intr_test_pkg::*;

    // ==================================================================
    // Run control
    // ==================================================================

    logic     state_active;
    intr_id_t cur_id;
    intr_id_t max_id;

    // Start command
    logic start_cmd;
    assign start_cmd = glob_wr.req && (glob_wr.idx == '0);

    // Request accepted by the host this cycle
    logic req_accept;
    assign req_accept = state_active && !host_waitrequest;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state_active <= 1'b0;
            cur_id       <= '0;
            max_id       <= '0;
        end
        else if (start_cmd)
        begin
            // Restart from ID 0 even in the middle of a run
            state_active <= 1'b1;
            cur_id       <= '0;
            max_id       <= glob_wr.data[INTR_ID_W-1:0];
        end
        else if (req_accept)
        begin
            // Last ID accepted ends the run
            state_active <= (cur_id != max_id);
            cur_id       <= cur_id + 1'b1;
        end
    end

    // ==================================================================
    // Request generation
    // ==================================================================

    // Request fields come straight from the registered state
    // Under waitrequest they hold because cur_id only moves on accept
    always_comb
    begin
        host_wr.write   = state_active;
        host_wr.address = HOST_ADDR_W'(cur_id);

        // Interrupt flag set, fence left clear
        host_wr.user                  = '0;
        host_wr.user[UFLAG_INTERRUPT] = 1'b1;

        // ID copy in user, echoed back with the response
        host_wr.user[UFLAG_ID_LSB +: INTR_ID_W] = cur_id;
    end

endmodule

/* csr_mgr.sv */
// MMIO register decoder

`timescale 1ns/1ps

module csr_mgr
(
    input  logic                    clk,
    input  logic                    reset_n,

    // MMIO request from software
    input  intr_test_pkg::mmio_req_t mmio,

    // Current value of every global register
    input  intr_test_pkg::csr_data_t glob_rd_data [intr_test_pkg::NUM_CSRS],

    // Read response
    output logic                    mmio_readdatavalid,
    output intr_test_pkg::csr_data_t mmio_readdata,

    // Write strobe to the engine blocks
    output intr_test_pkg::csr_wr_t  glob_wr
);

    import intr_test_pkg::*;

    // ==================================================================
    // Write path
    // ==================================================================

    // Every MMIO write becomes a one cycle pulse on glob_wr
    // Index and data follow the request with no qualification
    // Consumers only look at them while req is high
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            glob_wr.req <= 1'b0;
        end
        else
        begin
            glob_wr.req <= mmio.write;
        end
    end

    // Payload of the write pulse
    always_ff @(posedge clk)
    begin
        glob_wr.idx  <= mmio.address;
        glob_wr.data <= mmio.writedata;
    end

    // ==================================================================
    // Read path
    // ==================================================================

    // Requests are never stalled
    // The valid bit is the read strobe delayed by one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mmio_readdatavalid <= 1'b0;
        end
        else
        begin
            mmio_readdatavalid <= mmio.read;
        end
    end

    // Word selected by the register index
    csr_data_t rd_sel;

    always_comb
    begin
        rd_sel = glob_rd_data[mmio.address];
    end

    // Capture the selected word on a read
    // Hold it otherwise so the bus stays quiet between reads
    always_ff @(posedge clk)
    begin
        if (mmio.read)
        begin
            mmio_readdata <= rd_sel;
        end
    end

endmodule

/* intr_test_pkg.sv */
// Interrupt test engine
// Shared constants and types

package intr_test_pkg;

    // ==================================================================
    // Sizes
    // ==================================================================

    // Interrupt IDs handled by the engine
    localparam int NUM_INTR_IDS = 4;
    localparam int INTR_ID_W = 2;

    // Single engine reported in the configuration register
    localparam int NUM_ENGINES = 1;

    // Global register file
    localparam int NUM_CSRS = 16;
    localparam int CSR_IDX_W = 4;

    // Host write channel
    localparam int HOST_ADDR_W = 16;
    localparam int USER_W = 8;

    // ==================================================================
    // User bit layout on the host write channel
    // ==================================================================

    localparam int UFLAG_INTERRUPT = 0;
    localparam int UFLAG_FENCE = 1;
    // Interrupt ID rides above the flags
    localparam int UFLAG_ID_LSB = 2;

    // Test identifier returned by registers 0 and 1
    localparam logic [127:0] TEST_ID = 128'h4d3b_52e1_a07c_4f19_8b26_c1d5_7e90_3af4;

    // ==================================================================
    // Types
    // ==================================================================

    typedef logic [INTR_ID_W-1:0] intr_id_t;
    typedef logic [63:0] csr_data_t;

    // MMIO request from software
    typedef struct packed {
        logic                 write;
        logic                 read;
        logic [CSR_IDX_W-1:0] address;
        csr_data_t            writedata;
    } mmio_req_t;

    // Registered global register write
    typedef struct packed {
        logic                 req;
        logic [CSR_IDX_W-1:0] idx;
        csr_data_t            data;
    } csr_wr_t;

    // Host write request and response
    typedef struct packed {
        logic                   write;
        logic [HOST_ADDR_W-1:0] address;
        logic [USER_W-1:0]      user;
    } host_wr_req_t;

    typedef struct packed {
        logic              valid;
        logic [USER_W-1:0] user;
    } host_wr_rsp_t;

endpackage
